// File: source/fetch_params.svh
/*
 * sizes of the reference fetch buffer, one row word holds 64 luma pixels
 * window offsets above MAX_X are clamped, never wrapped into the next row
 */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ******************************
// pixel and row geometry
// ******************************
`define PIXEL_WIDTH     8       // bits per luma pixel
`define WORD_PIXELS     64      // pixels in one row word
`define WIN_PIXELS      16      // pixels in one output window
`define MAX_X           48      // last offset with a full window

// ******************************
// register file geometry
// ******************************
`define RF_DEPTH        128     // rows held
`define RF_ADDR_WIDTH   7       // log2 of depth
`define SUBBANK_WIDTH   128     // one sub-bank macro width

`endif

// File: source/fetch_pixel_pkg.sv
/*
 * pixel level types of the fetch buffer
 * pixel 0 of a row sits in the low bits, sub-bank 0 holds pixels 0..15
 */
`include "fetch_params.svh"

package fetch_pixel_pkg;

    // ******************************
    // sizes derived from the macros
    // ******************************
    localparam int unsigned ROW_WIDTH = `WORD_PIXELS * `PIXEL_WIDTH;   // 512
    localparam int unsigned RF_BANKS  = ROW_WIDTH / `SUBBANK_WIDTH;   // 4 macros

    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;       // one luma sample

    typedef logic [`SUBBANK_WIDTH-1:0] bank_word_t;   // one sub-bank row

    // one row word, seen either as pixels or as sub-bank slices
    typedef union packed {
        pixel_t     [`WORD_PIXELS-1:0] pix;       // window select view
        bank_word_t [RF_BANKS-1:0]     bank;      // memory split view
    } ref_word_u;

    typedef pixel_t [`WIN_PIXELS-1:0] win_t;      // 16 pixel output window

endpackage

// File: source/fetch_ctrl_pkg.sv
/*
 * control side types, counts run 1..128 and wider counts wrap the address
 */
`include "fetch_params.svh"

package fetch_ctrl_pkg;

    typedef logic [`RF_ADDR_WIDTH-1:0]     row_addr_t;   // row index, wraps at depth
    typedef logic [`RF_ADDR_WIDTH:0]       row_cnt_t;    // 1..128 rows
    typedef logic [$clog2(`WORD_PIXELS)-1:0] x_off_t;    // pixel offset in row

    // ******************************
    // sequencer states
    // ******************************
    typedef enum logic [1:0] {
        IDLE = 2'd0,        // waiting for a start
        LOAD = 2'd1,        // host writes rows
        READ = 2'd2         // one row read per cycle
    } ctrl_state_e;

endpackage

// File: source/fetch_ifs.sv
/*
 * internal buses of the fetch buffer, plain strobes without handshake
 * wdata is driven straight from the host port by the top level
 */
`timescale 1ns/10ps

// ******************************
// register file port
// ******************************
interface fetch_rf_if import fetch_pixel_pkg::*, fetch_ctrl_pkg::*; ();
    logic       we;         // write strobe, wins over re
    logic       re;         // read strobe
    row_addr_t  addr;       // shared row address
    ref_word_u  wdata;      // row to write
    ref_word_u  rdata;      // registered read row

    modport ctrl (output we, output re, output addr);
    modport mem  (input we, input re, input addr, input wdata, output rdata);
endinterface

// ******************************
// row address counter port
// ******************************
interface fetch_cnt_if import fetch_ctrl_pkg::*; ();
    logic       cnt_load;   // preset address and length
    row_addr_t  cnt_base;   // first row
    row_cnt_t   cnt_len;    // rows in the run
    logic       cnt_step;   // advance one row
    row_addr_t  cnt_addr;   // current row
    logic       cnt_last;   // current row is the final one

    modport fsm (output cnt_load, output cnt_base, output cnt_len, output cnt_step,
                 input cnt_addr, input cnt_last);
    modport cnt (input cnt_load, input cnt_base, input cnt_len, input cnt_step,
                 output cnt_addr, output cnt_last);
endinterface

// File: source/fetch_ctrl_fsm.sv
/*
 * load and fetch sequencer, starts count only in IDLE with a nonzero length
 * a load start wins over a fetch start raised in the same cycle
 */
`timescale 1ns/10ps

module fetch_ctrl_fsm import fetch_ctrl_pkg::*; (
    input  logic        clk,                // core clock
    input  logic        rst_i,              // sync reset, active high
    input  logic        load_start_i,       // begin a row load
    input  row_addr_t   load_base_i,        // first row to write
    input  row_cnt_t    load_rows_i,        // rows to write
    input  logic        load_we_i,          // one row per strobe
    input  logic        fetch_start_i,      // begin a row fetch
    input  row_addr_t   fetch_row_i,        // first row to read
    input  row_cnt_t    fetch_rows_i,       // rows to read
    input  x_off_t      fetch_x_i,          // window offset for the run
    output logic        busy_o,             // not in IDLE
    output logic        load_done_o,        // one cycle after the last write
    output logic        rd_issue_o,         // read issued this cycle
    output logic        rd_last_o,          // final read of the run
    output x_off_t      rd_x_o,             // offset held for the run
    fetch_rf_if.ctrl    rf,                 // memory strobes
    fetch_cnt_if.fsm    cnt                 // address counter
);

    ctrl_state_e state_q;       // current phase
    ctrl_state_e state_d;
    logic        load_acc;      // load start taken
    logic        fetch_acc;     // fetch start taken
    logic        load_done_q;
    x_off_t      x_q;           // latched search x

    assign load_acc  = (state_q == IDLE) & load_start_i & (load_rows_i != '0);
    assign fetch_acc = (state_q == IDLE) & ~load_acc & fetch_start_i &
                       (fetch_rows_i != '0);

    // ******************************
    // next state and strobes
    // ******************************
    always_comb begin
        state_d      = state_q;
        cnt.cnt_load = load_acc | fetch_acc;
        cnt.cnt_base = load_acc ? load_base_i : fetch_row_i;   // preset source
        cnt.cnt_len  = load_acc ? load_rows_i : fetch_rows_i;
        cnt.cnt_step = 1'b0;
        rf.we        = 1'b0;
        rf.re        = 1'b0;
        rd_issue_o   = 1'b0;
        rd_last_o    = 1'b0;
        case (state_q)
            IDLE: begin
                if (load_acc) begin
                    state_d = LOAD;
                end else if (fetch_acc) begin
                    state_d = READ;
                end
            end
            LOAD: begin
                rf.we        = load_we_i;       // gaps just wait
                cnt.cnt_step = load_we_i;
                if (load_we_i && cnt.cnt_last) begin
                    state_d = IDLE;
                end
            end
            READ: begin
                rf.re        = 1'b1;            // one row every cycle
                rd_issue_o   = 1'b1;
                rd_last_o    = cnt.cnt_last;
                cnt.cnt_step = 1'b1;
                if (cnt.cnt_last) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;            // unused encoding
        endcase
    end

    assign rf.addr     = cnt.cnt_addr;          // same address for load and fetch
    assign busy_o      = (state_q != IDLE);
    assign load_done_o = load_done_q;
    assign rd_x_o      = x_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= IDLE;
            load_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            load_done_q <= (state_q == LOAD) & load_we_i & cnt.cnt_last;   // single pulse
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_acc) begin
            x_q <= fetch_x_i;                   // held until the next fetch
        end
    end

endmodule

// File: source/fetch_addr_counter.sv
/*
 * row address counter, address wraps modulo the depth
 * stepping past a remaining count of zero is not guarded
 */
`timescale 1ns/10ps

module fetch_addr_counter import fetch_ctrl_pkg::*; (
    input  logic        clk,        // core clock
    input  logic        rst_i,      // sync reset, active high
    fetch_cnt_if.cnt    cnt         // preset, step and status
);

    row_addr_t addr_q;      // current row
    row_cnt_t  remain_q;    // rows still to go, this one included

    // ******************************
    // address and length
    // ******************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            addr_q   <= '0;
            remain_q <= '0;
        end else if (cnt.cnt_load) begin
            addr_q   <= cnt.cnt_base;           // start of run
            remain_q <= cnt.cnt_len;
        end else if (cnt.cnt_step) begin
            addr_q   <= addr_q + 1'b1;          // 127 rolls to 0
            remain_q <= remain_q - 1'b1;
        end
    end

    assign cnt.cnt_addr = addr_q;
    assign cnt.cnt_last = (remain_q == row_cnt_t'(1));   // final row of the phase

endmodule

// File: source/fetch_rf_1p_128x512.sv
/*
 * behavioral single port row buffer as four 128x128 sub-banks
 * write wins over read, rdata holds the last read row and starts unknown
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_rf_1p_128x512 import fetch_pixel_pkg::*; (
    input  logic        clk,        // core clock
    fetch_rf_if.mem     rf          // strobes, address and data
);

    // ******************************
    // storage
    // ******************************
    bank_word_t bank_mem [RF_BANKS][`RF_DEPTH];   // one array per macro
    ref_word_u  rd_q;                             // read register, all banks

    // every bank sees the same address and strobes, as the four macros do
    always_ff @(posedge clk) begin
        for (int b = 0; b < RF_BANKS; b++) begin
            if (rf.we) begin
                bank_mem[b][rf.addr] <= rf.wdata.bank[b];    // slice b of the row
            end else if (rf.re) begin
                rd_q.bank[b] <= bank_mem[b][rf.addr];        // read only when idle from write
            end
        end
    end

    assign rf.rdata = rd_q;     // held between reads

endmodule

// File: source/fetch_pixel_window.sv
/*
 * two stage window select, offsets above MAX_X are clamped to MAX_X
 * output follows rd_issue by two cycles with no stall
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_pixel_window import fetch_pixel_pkg::*, fetch_ctrl_pkg::*; (
    input  logic        clk,            // core clock
    input  logic        rst_i,          // sync reset, active high
    input  ref_word_u   rdata_i,        // row from the buffer
    input  logic        rd_issue_i,     // read issued
    input  logic        rd_last_i,      // final read
    input  x_off_t      rd_x_i,         // requested offset
    output logic        ref_valid_o,    // window valid
    output logic        ref_last_o,     // final window of the run
    output win_t        ref_pixels_o    // 16 pixels, pixel x in low bits
);

    logic   issue_q;        // row arrives this cycle
    logic   last_q;
    x_off_t x_clamp;
    x_off_t x_q;            // offset travelling with the row
    win_t   win_sel;

    assign x_clamp = (rd_x_i > x_off_t'(`MAX_X)) ? x_off_t'(`MAX_X) : rd_x_i;

    // ******************************
    // stage 1, align with read data
    // ******************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            issue_q <= rd_issue_i;
            last_q  <= rd_issue_i & rd_last_i;
        end
    end

    always_ff @(posedge clk) begin
        x_q <= x_clamp;         // per row, so back to back rows keep their own x
    end

    always_comb begin
        for (int i = 0; i < `WIN_PIXELS; i++) begin
            win_sel[i] = rdata_i.pix[x_q + i];   // x_q + 15 stays below 64
        end
    end

    // ******************************
    // stage 2, output register
    // ******************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ref_valid_o <= 1'b0;
            ref_last_o  <= 1'b0;
        end else begin
            ref_valid_o <= issue_q;
            ref_last_o  <= issue_q & last_q;
        end
    end

    always_ff @(posedge clk) begin
        ref_pixels_o <= win_sel;
    end

endmodule

// File: source/fetch_ref_top.sv
/*
 * reference pixel fetch buffer, no back-pressure on the window output
 * busy_o drops before the last two windows have drained
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_ref_top import fetch_ctrl_pkg::*; (
    input  logic                                clk,            // core clock
    input  logic                                rst_i,          // sync reset
    input  logic                                load_start_i,   // begin load
    input  row_addr_t                           load_base_i,    // first row to write
    input  row_cnt_t                            load_rows_i,    // rows to write
    input  logic                                load_we_i,      // row strobe
    input  logic [`WORD_PIXELS*`PIXEL_WIDTH-1:0] load_data_i,    // 64 pixels
    input  logic                                fetch_start_i,  // begin fetch
    input  row_addr_t                           fetch_row_i,    // first row to read
    input  row_cnt_t                            fetch_rows_i,   // rows to read
    input  x_off_t                              fetch_x_i,      // window offset
    output logic                                busy_o,         // phase active
    output logic                                load_done_o,    // load finished
    output logic                                ref_valid_o,    // window valid
    output logic                                ref_last_o,     // final window
    output logic [`WIN_PIXELS*`PIXEL_WIDTH-1:0]  ref_pixels_o    // 16 pixels
);

    logic   rd_issue;   // fsm to window pipe
    logic   rd_last;
    x_off_t rd_x;

    fetch_rf_if  rf_bus ();
    fetch_cnt_if cnt_bus ();

    assign rf_bus.wdata = load_data_i;      // host row straight to the banks

    fetch_ctrl_fsm fetch_ctrl_fsm_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .load_start_i   (load_start_i),
        .load_base_i    (load_base_i),
        .load_rows_i    (load_rows_i),
        .load_we_i      (load_we_i),
        .fetch_start_i  (fetch_start_i),
        .fetch_row_i    (fetch_row_i),
        .fetch_rows_i   (fetch_rows_i),
        .fetch_x_i      (fetch_x_i),
        .busy_o         (busy_o),
        .load_done_o    (load_done_o),
        .rd_issue_o     (rd_issue),
        .rd_last_o      (rd_last),
        .rd_x_o         (rd_x),
        .rf             (rf_bus),
        .cnt            (cnt_bus)
    );

    fetch_addr_counter fetch_addr_counter_inst (
        .clk    (clk),
        .rst_i  (rst_i),
        .cnt    (cnt_bus)
    );

    fetch_rf_1p_128x512 fetch_rf_1p_128x512_inst (
        .clk    (clk),
        .rf     (rf_bus)
    );

    fetch_pixel_window fetch_pixel_window_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .rdata_i        (rf_bus.rdata),
        .rd_issue_i     (rd_issue),
        .rd_last_i      (rd_last),
        .rd_x_i         (rd_x),
        .ref_valid_o    (ref_valid_o),
        .ref_last_o     (ref_last_o),
        .ref_pixels_o   (ref_pixels_o)
    );

endmodule

// File: sim/tb_fetch_ref_top.sv
/*
 * directed testbench for the reference fetch buffer
 * inputs change and outputs are sampled 2 ns after the rising edge
 * the model array mirrors every host write
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module tb_fetch_ref_top;

    localparam int ROW_W       = `WORD_PIXELS * `PIXEL_WIDTH;   // 512 bit row
    localparam int WIN_W       = `WIN_PIXELS * `PIXEL_WIDTH;    // 128 bit window
    localparam int X_W         = $clog2(`WORD_PIXELS);
    localparam int CYCLE_LIMIT = 2000;                          // tests use about 360

    logic                       clk;
    logic                       rst_i;
    logic                       load_start_i;
    logic [`RF_ADDR_WIDTH-1:0]  load_base_i;
    logic [`RF_ADDR_WIDTH:0]    load_rows_i;
    logic                       load_we_i;
    logic [ROW_W-1:0]           load_data_i;
    logic                       fetch_start_i;
    logic [`RF_ADDR_WIDTH-1:0]  fetch_row_i;
    logic [`RF_ADDR_WIDTH:0]    fetch_rows_i;
    logic [X_W-1:0]             fetch_x_i;
    logic                       busy_o;
    logic                       load_done_o;
    logic                       ref_valid_o;
    logic                       ref_last_o;
    logic [WIN_W-1:0]           ref_pixels_o;

    logic [ROW_W-1:0] model_mem [`RF_DEPTH];    // mirror of the row buffer
    integer seed = 32'h6285;                     // row data seed
    int cycle_cnt   = 0;
    int valid_total = 0;                         // every valid window seen
    int test_errs   = 0;
    int tests_run   = 0;
    int tests_bad   = 0;
    int errs_total  = 0;

    fetch_ref_top fetch_ref_top_inst (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;                       // 20 ns period

    // run limit ends the simulation if a test stalls
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    // ******************************
    // helpers
    // ******************************
    task automatic step();
        @(posedge clk);
        #2;                                      // outputs settled at the drive point
        if (ref_valid_o === 1'b1) valid_total++;
    endtask

    task automatic make_row(output logic [ROW_W-1:0] row);
        for (int w = 0; w < ROW_W / 32; w++) begin
            row[w*32 +: 32] = $random(seed);
        end
    endtask

    // window of the model row starting at pixel x
    function automatic logic [WIN_W-1:0] expect_win(input int row, input int x);
        logic [ROW_W-1:0] r;
        logic [WIN_W-1:0] w;
        r = model_mem[row % `RF_DEPTH];
        for (int i = 0; i < `WIN_PIXELS; i++) begin
            w[i*`PIXEL_WIDTH +: `PIXEL_WIDTH] = r[(x+i)*`PIXEL_WIDTH +: `PIXEL_WIDTH];
        end
        return w;
    endfunction

    task automatic mismatch(input string name, input string what,
                            input logic [WIN_W-1:0] exp, input logic [WIN_W-1:0] act);
        $display("FAILED %s %s: expected %0h actual %0h", name, what, exp, act);
        test_errs++;
    endtask

    task automatic problem(input string name, input string msg);
        $display("%s: %s", name, msg);           // non value failure
        test_errs++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errs_total += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // host load with optional gaps and a fetch start poked while busy
    task automatic load_rows(input string name, input int base, input int n,
                             input int gap, input bit poke_fetch);
        logic [ROW_W-1:0] row;
        int v0;
        v0           = valid_total;
        load_start_i = 1'b1;
        load_base_i  = base[`RF_ADDR_WIDTH-1:0];
        load_rows_i  = n[`RF_ADDR_WIDTH:0];
        step();
        load_start_i = 1'b0;
        if (busy_o !== 1'b1) problem(name, "load start was not accepted");
        for (int k = 0; k < n; k++) begin
            for (int g = 0; g < gap && k > 0; g++) begin
                if (poke_fetch && g == 0) begin
                    fetch_start_i = 1'b1;            // must be ignored
                    fetch_row_i   = '0;
                    fetch_rows_i  = 4;
                    fetch_x_i     = '0;
                end
                step();
                fetch_start_i = 1'b0;
                if (load_done_o !== 1'b0) problem(name, "load_done_o pulsed during a gap");
            end
            make_row(row);
            load_we_i   = 1'b1;
            load_data_i = row;
            model_mem[(base + k) % `RF_DEPTH] = row;   // wraps like the buffer
            step();
            load_we_i = 1'b0;
            if (load_done_o !== (k == n - 1)) begin
                mismatch(name, $sformatf("load_done_o after row %0d", k), k == n - 1,
                         load_done_o);
            end
        end
        step();
        if (load_done_o !== 1'b0) problem(name, "load_done_o lasted more than one cycle");
        if (busy_o !== 1'b0) problem(name, "busy_o still high after the load");
        repeat (3) step();                       // room for a stray window
        if (valid_total != v0) problem(name, "windows appeared during a load");
    endtask

    // fetch a run and check latency, order, pixels, last and count
    task automatic fetch_check(input string name, input int base, input int n,
                               input int x, input int exp_x);
        logic [WIN_W-1:0] exp;
        int v0;
        int wait_cnt;
        int got;
        v0            = valid_total;
        fetch_start_i = 1'b1;
        fetch_row_i   = base[`RF_ADDR_WIDTH-1:0];
        fetch_rows_i  = n[`RF_ADDR_WIDTH:0];
        fetch_x_i     = x[X_W-1:0];
        step();
        fetch_start_i = 1'b0;
        wait_cnt      = 1;
        while (ref_valid_o !== 1'b1 && wait_cnt < 10) begin
            step();
            wait_cnt++;
        end
        if (ref_valid_o !== 1'b1) begin
            problem(name, "no window arrived within 10 cycles of the start");
            return;
        end
        if (wait_cnt != 3) mismatch(name, "first window latency", 3, wait_cnt);
        for (int k = 0; k < n; k++) begin
            exp = expect_win(base + k, exp_x);
            if (ref_valid_o !== 1'b1) begin
                problem(name, $sformatf("window %0d missing, the run has a gap", k));
            end else if (ref_pixels_o !== exp) begin
                mismatch(name, $sformatf("row %0d pixels", (base + k) % `RF_DEPTH), exp,
                         ref_pixels_o);
            end
            if (ref_last_o !== (k == n - 1)) begin
                mismatch(name, $sformatf("ref_last_o on window %0d", k), k == n - 1, ref_last_o);
            end
            step();
        end
        got = valid_total - v0;
        if (got != n) mismatch(name, "valid window count", n, got);
        if (busy_o !== 1'b0) problem(name, "busy_o still high after the fetch");
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic test_reset();
        if (busy_o !== 1'b0) mismatch("reset_values", "busy_o", 0, busy_o);
        if (load_done_o !== 1'b0) mismatch("reset_values", "load_done_o", 0, load_done_o);
        if (ref_valid_o !== 1'b0) mismatch("reset_values", "ref_valid_o", 0, ref_valid_o);
        if (ref_last_o !== 1'b0) mismatch("reset_values", "ref_last_o", 0, ref_last_o);
        end_test("reset_values");
    endtask

    task automatic test_load_fetch();
        load_rows("load_fetch", 0, 8, 0, 1'b0);
        fetch_check("load_fetch", 0, 8, 0, 0);
        end_test("load_fetch");
    endtask

    task automatic test_offsets();
        fetch_check("offset_x17", 0, 8, 17, 17);
        fetch_check("offset_x60", 0, 8, 60, 48);   // clamped to the last window
        end_test("window_offsets");
    endtask

    task automatic test_wrap();
        load_rows("wraparound", 126, 4, 0, 1'b0);  // rows 126, 127, 0, 1
        fetch_check("wraparound", 126, 4, 9, 9);
        end_test("wraparound");
    endtask

    task automatic test_gaps();
        int v0;
        load_rows("gaps_ignored", 40, 4, 2, 1'b1);
        v0            = valid_total;
        fetch_start_i = 1'b1;                      // zero count fetch
        fetch_rows_i  = '0;
        load_start_i  = 1'b0;
        step();
        fetch_start_i = 1'b0;
        load_start_i  = 1'b1;                      // zero count load
        load_rows_i   = '0;
        step();
        load_start_i = 1'b0;
        repeat (4) begin
            step();
            if (busy_o !== 1'b0) problem("gaps_ignored", "zero count start made the DUT busy");
        end
        if (valid_total != v0) problem("gaps_ignored", "zero count fetch produced windows");
        fetch_check("gaps_ignored", 40, 4, 5, 5);  // rows written across the gaps
        end_test("gaps_ignored");
    endtask

    task automatic test_full();
        load_rows("full_buffer", 0, 128, 0, 1'b0);
        fetch_check("full_buffer", 5, 128, 33, 33);
        end_test("full_buffer");
    endtask

    initial begin
        rst_i         = 1'b1;
        load_start_i  = 1'b0;
        load_base_i   = '0;
        load_rows_i   = '0;
        load_we_i     = 1'b0;
        load_data_i   = '0;
        fetch_start_i = 1'b0;
        fetch_row_i   = '0;
        fetch_rows_i  = '0;
        fetch_x_i     = '0;
        repeat (2) @(posedge clk);                 // two reset cycles
        #2;
        rst_i = 1'b0;

        test_reset();
        test_load_fetch();
        test_offsets();
        test_wrap();
        test_gaps();
        test_full();

        $display("%0d tests run, %0d with errors, %0d wrong checks",
                 tests_run, tests_bad, errs_total);
        if (tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: fetch_ref_top.f
+incdir+source
source/fetch_pixel_pkg.sv
source/fetch_ctrl_pkg.sv
source/fetch_ifs.sv
source/fetch_ctrl_fsm.sv
source/fetch_addr_counter.sv
source/fetch_rf_1p_128x512.sv
source/fetch_pixel_window.sv
source/fetch_ref_top.sv
sim/tb_fetch_ref_top.sv

// File: Bender.yml
package:
  name: fetch_ref

# headers shared by the design and the testbench
export_include_dirs:
  - source

sources:
  # design, in compile order
  - files:
      - source/fetch_pixel_pkg.sv
      - source/fetch_ctrl_pkg.sv
      - source/fetch_ifs.sv
      - source/fetch_ctrl_fsm.sv
      - source/fetch_addr_counter.sv
      - source/fetch_rf_1p_128x512.sv
      - source/fetch_pixel_window.sv
      - source/fetch_ref_top.sv

  # testbench, top module tb_fetch_ref_top
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_fetch_ref_top.sv
